//--- logic/jtag_pkg.sv
// Widths of the JTAG side of the design
package jtag_pkg;

    // Bits per character shifted through the USER data register
    localparam int byte_width = 8;

    // Width of the result register read back on tdo
    localparam int result_width = 16;

endpackage

//--- logic/grid_pkg.sv
// Puzzle encodings and limits
package grid_pkg;

    // Character codes in the inbound stream
    localparam logic [7:0] char_rop     = 8'h40;
    localparam logic [7:0] char_empty   = 8'h2E;
    localparam logic [7:0] char_newline = 8'h0A;

    // A roll is accessible when fewer neighbours than this hold rolls
    localparam int accessible_limit = 4;

    // Line buffer depth, the widest row the design accepts
    localparam int default_max_row_width = 160;

endpackage

//--- logic/tap_decoder.sv
`timescale 1ns/100ps

module tap_decoder
    import jtag_pkg::*;
(
    input  logic                  tck,
    input  logic                  rst,
    // TAP state levels
    input  logic                  tdi,
    input  logic                  ir_is_user,
    input  logic                  shift_dr,
    input  logic                  update_dr,
    // Deserialized byte stream
    output logic                  valid,
    output logic [byte_width-1:0] data
);

    localparam int bit_cnt_width = $clog2(byte_width);

    logic [bit_cnt_width-1:0] bit_cnt;
    logic                     user_shift;

    assign user_shift = ir_is_user && shift_dr;

    // LSB arrives first, so new bits enter at the top
    always_ff @(posedge tck) begin
        if (user_shift) begin
            data <= {tdi, data[byte_width-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            bit_cnt <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= user_shift && (bit_cnt == bit_cnt_width'(byte_width - 1));
            // Update ends the scan, a partial byte is dropped
            if (update_dr) begin
                bit_cnt <= '0;
            end else if (user_shift) begin
                bit_cnt <= bit_cnt + bit_cnt_width'(1);
            end
        end
    end

    // Byte completes only on the edge after a shift cycle
    assert property (@(posedge tck) disable iff (rst)
        valid |-> $past(shift_dr));

endmodule

//--- logic/input_decoder.sv
`timescale 1ns/100ps

module input_decoder
    import jtag_pkg::*;
    import grid_pkg::*;
(
    input  logic                  tck,
    input  logic                  rst,
    // Inbound byte stream
    input  logic                  byte_valid,
    input  logic [byte_width-1:0] byte_data,
    // Cell stream
    output logic                  cell_last,
    output logic                  cell_valid,
    output logic                  cell_rop,
    output logic                  grid_end
);

    logic is_rop;
    logic is_cell;
    logic is_newline;

    // One cell held back until we know whether it ends the row
    logic pend_valid;
    logic pend_rop;
    logic newline_seen;

    always_comb begin
        is_rop     = (byte_data == char_rop);
        is_cell    = is_rop || (byte_data == char_empty);
        is_newline = (byte_data == char_newline);
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            pend_valid   <= 1'b0;
            newline_seen <= 1'b0;
            cell_valid   <= 1'b0;
            cell_last    <= 1'b0;
            grid_end     <= 1'b0;
        end else begin
            cell_valid <= 1'b0;
            cell_last  <= 1'b0;
            grid_end   <= 1'b0;
            if (byte_valid && is_cell) begin
                cell_valid   <= pend_valid;
                pend_valid   <= 1'b1;
                newline_seen <= 1'b0;
            end else if (byte_valid && is_newline) begin
                // Release the pending cell as the row end
                cell_valid   <= pend_valid;
                cell_last    <= pend_valid;
                pend_valid   <= 1'b0;
                // Blank line closes the grid
                grid_end     <= !pend_valid && newline_seen;
                newline_seen <= pend_valid || !newline_seen;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (byte_valid && (is_cell || is_newline)) begin
            cell_rop <= pend_rop;
        end
        if (byte_valid && is_cell) begin
            pend_rop <= is_rop;
        end
    end

    // Row end only travels with a cell
    assert property (@(posedge tck) disable iff (rst)
        cell_last |-> cell_valid);

endmodule

//--- logic/adjacent_rop_counter.sv
`timescale 1ns/100ps

module adjacent_rop_counter
    import grid_pkg::*;
#(
    parameter int max_row_width   = default_max_row_width,
    parameter int count_rop_width = 3
) (
    input  logic                       tck,
    input  logic                       rst,
    // Binary row data
    input  logic                       bin_last,
    input  logic                       bin_valid,
    input  logic                       bin_rop,
    input  logic                       grid_end,
    // Neighbour counts, one row behind the input
    output logic                       count_last,
    output logic                       count_valid,
    output logic [count_rop_width-1:0] count_rop,
    output logic                       count_cell,
    output logic                       count_done
);

    localparam int col_width = $clog2(max_row_width);
    // Top bit alone marks a saturated count
    localparam int rop_sat   = 2 ** (count_rop_width - 1);

    localparam logic [1:0] st_first = 2'd0;
    localparam logic [1:0] st_rows  = 2'd1;
    localparam logic [1:0] st_flush = 2'd2;
    localparam logic [1:0] st_done  = 2'd3;

    logic [1:0]           state;
    logic [col_width-1:0] col;
    logic [col_width-1:0] last_col;

    // Row above and row being emitted
    logic prev_row [max_row_width];
    logic cur_row  [max_row_width];

    // Window columns, bit 2 top, bit 1 centre row, bit 0 bottom
    logic [2:0] win_l;
    logic [2:0] win_c;
    logic [2:0] win_r;

    logic                       tail;
    logic                       flushing;
    logic                       step;
    logic                       step_last;
    logic                       advance;
    logic                       new_bot;
    logic                       emit;
    logic [3:0]                 neighbours;
    logic [count_rop_width-1:0] sat_count;

    assign flushing  = (state == st_flush);
    // One column of the three rows enters the window per step
    assign step      = flushing || (state == st_rows && bin_valid);
    assign advance   = step || (state == st_first && bin_valid);
    assign step_last = flushing ? (col == last_col) : bin_last;
    // Below the final row everything is empty
    assign new_bot   = !flushing && bin_rop;

    // Right edge of the row is empty
    assign win_r = tail ? 3'b000 : {prev_row[col], cur_row[col], new_bot};
    assign emit  = tail || (step && col != '0);

    assign neighbours = 4'(win_l[2]) + 4'(win_l[1]) + 4'(win_l[0])
                      + 4'(win_c[2]) + 4'(win_c[0])
                      + 4'(win_r[2]) + 4'(win_r[1]) + 4'(win_r[0]);

    assign sat_count = (neighbours >= 4'(rop_sat)) ? count_rop_width'(rop_sat)
                                                   : count_rop_width'(neighbours);

    always_ff @(posedge tck) begin
        if (state == st_first && bin_valid) begin
            prev_row[col] <= 1'b0;
            cur_row[col]  <= bin_rop;
        end else if (step) begin
            prev_row[col] <= cur_row[col];
            cur_row[col]  <= new_bot;
        end
    end

    always_ff @(posedge tck) begin
        if (step) begin
            // Left edge of the row is empty
            win_l <= (col == '0) ? 3'b000 : win_c;
            win_c <= win_r;
        end
        if (bin_valid && bin_last) begin
            last_col <= col;
        end
        if (emit) begin
            count_rop  <= sat_count;
            count_cell <= win_c[1];
        end
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            state       <= st_first;
            col         <= '0;
            tail        <= 1'b0;
            count_valid <= 1'b0;
            count_last  <= 1'b0;
            count_done  <= 1'b0;
        end else begin
            count_valid <= emit;
            count_last  <= tail;
            count_done  <= 1'b0;
            // Last column still needs its own cycle
            tail        <= step && step_last;
            if (advance) begin
                col <= step_last ? '0 : col + col_width'(1);
            end
            case (state)
                st_first: begin
                    if (bin_valid && bin_last) begin
                        state <= st_rows;
                    end else if (grid_end) begin
                        // Grid without rows
                        count_done <= 1'b1;
                    end
                end
                st_rows: begin
                    if (grid_end) begin
                        state <= st_flush;
                    end
                end
                st_flush: begin
                    if (step_last) begin
                        state <= st_done;
                    end
                end
                default: begin
                    // Wait for the tail count to leave
                    if (!tail) begin
                        count_done <= 1'b1;
                        state      <= st_first;
                    end
                end
            endcase
        end
    end

    // Rows must fit the line buffers
    assert property (@(posedge tck) disable iff (rst)
        (advance && col == col_width'(max_row_width - 1)) |-> step_last);

    assert property (@(posedge tck) disable iff (rst)
        count_valid |-> count_rop <= count_rop_width'(rop_sat));

endmodule

//--- logic/accessible_counter.sv
`timescale 1ns/100ps

module accessible_counter
    import jtag_pkg::*;
    import grid_pkg::*;
#(
    parameter int count_rop_width = 3
) (
    input  logic                       tck,
    input  logic                       rst,
    // Neighbour counts per cell
    input  logic                       count_valid,
    input  logic [count_rop_width-1:0] count_rop,
    input  logic                       count_cell,
    input  logic                       count_done,
    // Count of the last finished grid
    output logic [result_width-1:0]    result
);

    logic [result_width-1:0] running;
    logic                    accessible;

    assign accessible = count_valid && count_cell
                        && (count_rop < count_rop_width'(accessible_limit));

    always_ff @(posedge tck) begin
        if (rst) begin
            running <= '0;
            result  <= '0;
        end else if (count_done) begin
            result  <= running;
            running <= '0;
        end else if (accessible) begin
            running <= running + result_width'(1);
        end
    end

endmodule

//--- logic/tap_encoder.sv
`timescale 1ns/100ps

module tap_encoder
    import jtag_pkg::*;
(
    input  logic                    tck,
    input  logic                    rst,
    // TAP state levels
    input  logic                    ir_is_user,
    input  logic                    capture_dr,
    input  logic                    shift_dr,
    input  logic                    tdi,
    // Value to report
    input  logic [result_width-1:0] data,
    output logic                    tdo
);

    logic [result_width-1:0] shift_reg;

    always_ff @(posedge tck) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (ir_is_user) begin
            if (capture_dr) begin
                shift_reg <= data;
            end else if (shift_dr) begin
                // LSB leaves first, tdi fills from the top
                shift_reg <= {tdi, shift_reg[result_width-1:1]};
            end
        end
    end

    assign tdo = shift_reg[0];

endmodule

//--- logic/user_logic.sv
`timescale 1ns/100ps

module user_logic
    import jtag_pkg::*;
    import grid_pkg::*;
#(
    parameter int max_row_width   = default_max_row_width,
    // Neighbour count saturates at 4, three bits
    parameter int count_rop_width = 3
) (
    input  logic tck,
    input  logic rst,
    input  logic tdi,
    output logic tdo,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr
);

    logic                       inbound_valid;
    logic [byte_width-1:0]      inbound_data;

    logic                       cell_last;
    logic                       cell_valid;
    logic                       cell_rop;
    logic                       grid_end;

    logic                       count_valid;
    logic [count_rop_width-1:0] count_rop;
    logic                       count_cell;
    logic                       count_done;

    logic [result_width-1:0]    result;

    tap_decoder tap_decoder_i (
        .tck        (tck),
        .rst        (rst),
        .tdi        (tdi),
        .ir_is_user (ir_is_user),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .valid      (inbound_valid),
        .data       (inbound_data)
    );

    input_decoder input_decoder_i (
        .tck        (tck),
        .rst        (rst),
        .byte_valid (inbound_valid),
        .byte_data  (inbound_data),
        .cell_last  (cell_last),
        .cell_valid (cell_valid),
        .cell_rop   (cell_rop),
        .grid_end   (grid_end)
    );

    adjacent_rop_counter #(
        .max_row_width   (max_row_width),
        .count_rop_width (count_rop_width)
    ) adjacent_rop_counter_i (
        .tck         (tck),
        .rst         (rst),
        .bin_last    (cell_last),
        .bin_valid   (cell_valid),
        .bin_rop     (cell_rop),
        .grid_end    (grid_end),
        .count_last  (),
        .count_valid (count_valid),
        .count_rop   (count_rop),
        .count_cell  (count_cell),
        .count_done  (count_done)
    );

    accessible_counter #(
        .count_rop_width (count_rop_width)
    ) accessible_counter_i (
        .tck         (tck),
        .rst         (rst),
        .count_valid (count_valid),
        .count_rop   (count_rop),
        .count_cell  (count_cell),
        .count_done  (count_done),
        .result      (result)
    );

    tap_encoder tap_encoder_i (
        .tck        (tck),
        .rst        (rst),
        .ir_is_user (ir_is_user),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .tdi        (tdi),
        .data       (result),
        .tdo        (tdo)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic tck,
    output logic rst
);

    // 40 ns period
    initial begin
        tck = 1'b0;
        forever #20 tck = ~tck;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge tck);
        rst <= 1'b0;
    end

endmodule

//--- testbench/tb_user_logic.sv
`timescale 1ns/100ps

module tb_user_logic
    import jtag_pkg::*;
    import grid_pkg::*;
;

    localparam int tb_row_width    = 16;
    localparam int rand_grid_chars = 12 * (tb_row_width + 1) + 1;
    // Example, 3x3, three random grids, the short grids and the partial byte
    localparam int total_chars     = 111 + 13 + 3 * rand_grid_chars + 16;
    localparam int shift_cycles    = byte_width * total_chars + 8 * (result_width + 3);
    localparam int watchdog_cycles = 2 * shift_cycles + 2000;

    logic tck;
    logic rst;
    logic tdi;
    logic tdo;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    int          errors = 0;
    logic [31:0] rng_state = 32'ha862_cb77;

    tb_clock u_clock (
        .tck (tck),
        .rst (rst)
    );

    user_logic #(
        .max_row_width (tb_row_width)
    ) u_dut (
        .tck        (tck),
        .rst        (rst),
        .tdi        (tdi),
        .tdo        (tdo),
        .ir_is_user (ir_is_user),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Counts accessible rolls straight from the characters
    function automatic logic [result_width-1:0] model_count(string s);
        logic cells [32][32];
        int   row_len [32];
        int   rows;
        int   col;
        int   total;
        int   n;
        rows  = 0;
        col   = 0;
        total = 0;
        for (int r = 0; r < 32; r++) begin
            row_len[r] = 0;
            for (int c = 0; c < 32; c++) begin
                cells[r][c] = 1'b0;
            end
        end
        for (int i = 0; i < s.len(); i++) begin
            if (s[i] == char_newline) begin
                // Blank line ends the grid
                if (col == 0) begin
                    break;
                end
                row_len[rows] = col;
                rows++;
                col = 0;
            end else if (s[i] == char_rop || s[i] == char_empty) begin
                cells[rows][col] = (s[i] == char_rop);
                col++;
            end
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < row_len[r]; c++) begin
                if (cells[r][c]) begin
                    n = 0;
                    for (int dr = -1; dr <= 1; dr++) begin
                        for (int dc = -1; dc <= 1; dc++) begin
                            if ((dr != 0 || dc != 0) && r + dr >= 0 && r + dr < 32
                                && c + dc >= 0 && c + dc < 32 && cells[r + dr][c + dc]) begin
                                n++;
                            end
                        end
                    end
                    if (n < accessible_limit) begin
                        total++;
                    end
                end
            end
        end
        return result_width'(total);
    endfunction

    function automatic string random_grid();
        string s;
        int    width;
        int    rows;
        s     = "";
        width = 1 + int'(lcg_next() >> 16) % tb_row_width;
        rows  = 1 + int'(lcg_next() >> 16) % 12;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < width; c++) begin
                // Roughly 60 percent rolls
                if (int'(lcg_next() >> 16) % 10 < 6) begin
                    s = {s, "@"};
                end else begin
                    s = {s, "."};
                end
            end
            s = {s, "\n"};
        end
        return {s, "\n"};
    endfunction

    task automatic check_result(string name, logic [result_width-1:0] expected,
                                logic [result_width-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR t=%0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic shift_bits(logic [byte_width-1:0] c, int nbits, logic user);
        for (int i = 0; i < nbits; i++) begin
            @(posedge tck);
            tdi        <= c[i];
            shift_dr   <= 1'b1;
            ir_is_user <= user;
        end
    endtask

    task automatic end_scan();
        @(posedge tck);
        tdi        <= 1'b0;
        shift_dr   <= 1'b0;
        update_dr  <= 1'b1;
        ir_is_user <= 1'b1;
        @(posedge tck);
        update_dr  <= 1'b0;
    endtask

    // Whole string in one scan, then room for the final flush
    task automatic shift_string(string s, logic user);
        for (int i = 0; i < s.len(); i++) begin
            shift_bits(s[i], byte_width, user);
        end
        end_scan();
        repeat (tb_row_width + 4) @(posedge tck);
    endtask

    task automatic read_result(output logic [result_width-1:0] value);
        @(posedge tck);
        ir_is_user <= 1'b1;
        capture_dr <= 1'b1;
        @(posedge tck);
        capture_dr <= 1'b0;
        shift_dr   <= 1'b1;
        for (int i = 0; i < result_width; i++) begin
            @(negedge tck);
            value[i] = tdo;
            @(posedge tck);
        end
        shift_dr  <= 1'b0;
        update_dr <= 1'b1;
        @(posedge tck);
        update_dr <= 1'b0;
    endtask

    task automatic test_reset_read();
        logic [result_width-1:0] value;
        @(negedge tck);
        check_bit("tdo", 1'b0, tdo);
        read_result(value);
        check_result("result after reset", '0, value);
    endtask

    task automatic test_full_grid();
        logic [result_width-1:0] value;
        string                   s;
        s = "@@@\n@@@\n@@@\n\n";
        shift_string(s, 1'b1);
        read_result(value);
        check_result("model 3x3", result_width'(4), model_count(s));
        check_result("result 3x3", result_width'(4), value);
    endtask

    task automatic test_example_grid();
        logic [result_width-1:0] value;
        string                   s;
        s = {"..@@.@@@@.\n", "@@@.@.@.@@\n", "@@@@@.@.@@\n", "@.@@@@..@.\n",
             "@@.@@@@.@@\n", ".@@@@@@@.@\n", ".@.@.@.@@@\n", "@.@@@.@@@@\n",
             ".@@@@@@@@.\n", "@.@.@@@.@.\n", "\n"};
        shift_string(s, 1'b1);
        read_result(value);
        check_result("model example", result_width'(13), model_count(s));
        check_result("result example", model_count(s), value);
    endtask

    task automatic test_random_grids();
        logic [result_width-1:0] value;
        string                   s;
        for (int g = 0; g < 3; g++) begin
            s = random_grid();
            shift_string(s, 1'b1);
            read_result(value);
            check_result($sformatf("result random %0d", g), model_count(s), value);
        end
    endtask

    task automatic test_partial_byte();
        logic [result_width-1:0] value;
        string                   s;
        s = "@@@@@\n\n";
        // Five bits only, update must drop them
        shift_bits(char_rop, 5, 1'b1);
        end_scan();
        shift_string(s, 1'b1);
        read_result(value);
        check_result("result after partial byte", model_count(s), value);
    endtask

    task automatic test_not_user();
        logic [result_width-1:0] value;
        shift_string("@\n\n", 1'b0);
        read_result(value);
        check_result("result with user off", model_count("@@@@@\n\n"), value);
    endtask

    initial begin
        tdi        <= 1'b0;
        ir_is_user <= 1'b1;
        capture_dr <= 1'b0;
        shift_dr   <= 1'b0;
        update_dr  <= 1'b0;
        @(negedge rst);
        @(posedge tck);
        test_reset_read();
        test_full_grid();
        test_example_grid();
        test_random_grids();
        test_partial_byte();
        test_not_user();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge tck);
        $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- user_logic.f
logic/jtag_pkg.sv
logic/grid_pkg.sv
logic/tap_decoder.sv
logic/input_decoder.sv
logic/adjacent_rop_counter.sv
logic/accessible_counter.sv
logic/tap_encoder.sv
logic/user_logic.sv
testbench/tb_clock.sv
testbench/tb_user_logic.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wall -Wno-fatal --assert
TOP       = tb_user_logic
FILELIST  = user_logic.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
